// ==== Makefile ====
TOP = cache_tag_ram_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sources.f

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Result: FAILED" sim.log; then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "Result: PASSED" sim.log; then echo "Simulation ended early"; exit 1; fi

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f sources.f

clean:
	rm -rf obj_dir sim.log

// ==== logic/cache_pkg.sv ====
// Cache store definitions.
// Tag layout, bus request word and burst types shared by the tag and data
// store and its write-back engine.

package cache_pkg;

// Width of the virtual tag field.
localparam int VTAG_W = 20;

// Lines examined in one scan step.
localparam int GROUP_LINES = 16;

// ----------------------------------------------------------------------

// Stored tag word.
typedef struct packed {
        logic [VTAG_W-1:0] vtag;
        // Physical byte address of the line start.
        logic [31:0]       pa;
} cache_tag_t;

// Bus cycle type identifiers.
typedef enum logic [2:0] {
        CTI_BURST = 3'b010,
        CTI_EOB   = 3'b111
} cti_e;

// ----------------------------------------------------------------------

// One bus request as driven by the write-back engine.
typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        wen;
        logic [3:0]  sel;
        logic [31:0] adr;
        logic [31:0] dat;
        cti_e        cti;
} wb_req_t;

endpackage

// ==== logic/cache_tag_ram.sv ====
// Direct-mapped cache tag and data store.
// Holds line data, tags and valid/dirty state, and writes dirty lines
// back over its own bus port on a clean request.

`timescale 1ns/100ps

module cache_tag_ram import cache_pkg::*; #(
        parameter int  CACHE_SIZE = 1024,
        parameter int  CACHE_LINE = 16,
        localparam int LINES      = CACHE_SIZE / CACHE_LINE,
        localparam int IDX_W      = $clog2(LINES),
        localparam int OFF_W      = $clog2(CACHE_LINE),
        localparam int GROUPS     = LINES / GROUP_LINES,
        localparam int GRP_W      = (GROUPS > 1) ? $clog2(GROUPS) : 1
)(
        input  logic                    i_clk,
        input  logic                    i_reset,
        input  logic [31:0]             i_address_nxt,
        input  logic [31:0]             i_address,
        input  logic                    i_line_wr_en,
        input  logic [CACHE_LINE*8-1:0] i_line,
        input  logic                    i_tag_wr_en,
        input  cache_tag_t              i_tag,
        input  logic                    i_tag_dirty,
        input  logic                    i_clean_req,
        input  logic                    i_inv_req,
        input  logic                    i_wb_ack,
        output logic [CACHE_LINE*8-1:0] o_line,
        output cache_tag_t              o_tag,
        output logic                    o_tag_valid,
        output logic                    o_tag_dirty,
        output logic                    o_clean_done,
        output logic                    o_inv_done,
        output wb_req_t                 o_wb
);

logic [IDX_W-1:0] wr_index;
logic [IDX_W-1:0] rd_index;
logic [IDX_W-1:0] found_index;
logic [LINES-1:0] dirty_vec;
logic [GRP_W-1:0] group;
logic             tag_wr_en;
logic             clean;
logic             clear;
logic             found;

// Index sits just above the line offset.
assign wr_index = i_address[OFF_W +: IDX_W];

// ----------------------------------------------------------------------
// Storage.

line_ram #(
        .WIDTH     (CACHE_LINE * 8),
        .DEPTH     (LINES)
) u_data_ram (
        .i_clk     (i_clk),
        .i_wr_en   (i_line_wr_en),
        .i_wr_addr (wr_index),
        .i_rd_addr (rd_index),
        .i_wr_data (i_line),
        .o_rd_data (o_line)
);

line_ram #(
        .WIDTH     ($bits(cache_tag_t)),
        .DEPTH     (LINES)
) u_tag_ram (
        .i_clk     (i_clk),
        .i_wr_en   (tag_wr_en),
        .i_wr_addr (wr_index),
        .i_rd_addr (rd_index),
        .i_wr_data (i_tag),
        .o_rd_data (o_tag)
);

line_state #(
        .CACHE_SIZE  (CACHE_SIZE),
        .CACHE_LINE  (CACHE_LINE)
) u_line_state (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_rd_addr   (rd_index),
        .i_wr_addr   (wr_index),
        .i_wr_en     (tag_wr_en),
        .i_wr_dirty  (i_tag_dirty),
        .i_clean     (clean),
        .i_clear     (clear),
        .o_valid     (o_tag_valid),
        .o_dirty     (o_tag_dirty),
        .o_dirty_vec (dirty_vec)
);

// ----------------------------------------------------------------------
// Clean and invalidate control.

dirty_scan #(
        .CACHE_SIZE  (CACHE_SIZE),
        .CACHE_LINE  (CACHE_LINE)
) u_dirty_scan (
        .i_dirty_vec (dirty_vec),
        .i_group     (group),
        .o_found     (found),
        .o_index     (found_index)
);

clean_engine #(
        .CACHE_SIZE    (CACHE_SIZE),
        .CACHE_LINE    (CACHE_LINE)
) u_clean_engine (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_address_nxt (i_address_nxt),
        .i_tag_wr_en   (i_tag_wr_en),
        .i_clean_req   (i_clean_req),
        .i_inv_req     (i_inv_req),
        .i_wb_ack      (i_wb_ack),
        .i_line        (o_line),
        .i_tag         (o_tag),
        .i_found       (found),
        .i_found_index (found_index),
        .o_group       (group),
        .o_rd_index    (rd_index),
        .o_tag_wr_en   (tag_wr_en),
        .o_clean       (clean),
        .o_clear       (clear),
        .o_clean_done  (o_clean_done),
        .o_inv_done    (o_inv_done),
        .o_wb          (o_wb)
);

endmodule

// ==== logic/clean_engine.sv ====
// Clean and invalidate sequencer.
// Walks the dirty lines group by group, writes each one back as a bus
// burst to its physical address, and clears all valid bits on request.

`timescale 1ns/100ps

module clean_engine import cache_pkg::*; #(
        parameter int  CACHE_SIZE = 1024,
        parameter int  CACHE_LINE = 16,
        localparam int LINES      = CACHE_SIZE / CACHE_LINE,
        localparam int IDX_W      = $clog2(LINES),
        localparam int OFF_W      = $clog2(CACHE_LINE),
        localparam int GROUPS     = LINES / GROUP_LINES,
        localparam int GRP_W      = (GROUPS > 1) ? $clog2(GROUPS) : 1
)(
        input  logic                    i_clk,
        input  logic                    i_reset,
        input  logic [31:0]             i_address_nxt,
        input  logic                    i_tag_wr_en,
        input  logic                    i_clean_req,
        input  logic                    i_inv_req,
        input  logic                    i_wb_ack,
        input  logic [CACHE_LINE*8-1:0] i_line,
        input  cache_tag_t              i_tag,
        input  logic                    i_found,
        input  logic [IDX_W-1:0]        i_found_index,
        output logic [GRP_W-1:0]        o_group,
        output logic [IDX_W-1:0]        o_rd_index,
        output logic                    o_tag_wr_en,
        output logic                    o_clean,
        output logic                    o_clear,
        output logic                    o_clean_done,
        output logic                    o_inv_done,
        output wb_req_t                 o_wb
);

localparam int WORDS = CACHE_LINE / 4;
localparam int CNT_W = $clog2(WORDS) + 1;

typedef enum logic [2:0] {
        IDLE,
        SCAN,
        READ_WAIT,
        WRITE,
        INVALIDATE
} state_t;

state_t           state;
state_t           state_nxt;
logic [GRP_W-1:0] group;
logic [GRP_W-1:0] group_nxt;
logic [IDX_W-1:0] line_idx;
logic [IDX_W-1:0] line_idx_nxt;
logic [CNT_W-1:0] word;
logic [CNT_W-1:0] word_nxt;
logic             clean_done;
logic             clean_done_nxt;
wb_req_t          wb;
wb_req_t          wb_nxt;

assign o_group      = group;
assign o_clean_done = clean_done;
assign o_wb         = wb;

// ----------------------------------------------------------------------

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                state      <= IDLE;
                group      <= '0;
                line_idx   <= '0;
                word       <= '0;
                clean_done <= 1'b0;
                wb.cyc     <= 1'b0;
                wb.stb     <= 1'b0;
                wb.cti     <= CTI_EOB;
        end
        else
        begin
                state      <= state_nxt;
                group      <= group_nxt;
                line_idx   <= line_idx_nxt;
                word       <= word_nxt;
                clean_done <= clean_done_nxt;
                wb         <= wb_nxt;
        end
end

// ----------------------------------------------------------------------

always_comb
begin
        state_nxt      = state;
        group_nxt      = group;
        line_idx_nxt   = line_idx;
        word_nxt       = word;
        clean_done_nxt = 1'b0;
        wb_nxt         = wb;
        o_rd_index     = line_idx;
        o_tag_wr_en    = 1'b0;
        o_clean        = 1'b0;
        o_clear        = 1'b0;
        o_inv_done     = 1'b0;

        case (state)
        IDLE:
        begin
                o_rd_index  = i_address_nxt[OFF_W +: IDX_W];
                o_tag_wr_en = i_tag_wr_en;

                // No new request while the previous clean reports done.
                if (i_clean_req && !clean_done)
                begin
                        group_nxt = '0;
                        state_nxt = SCAN;
                end
                else if (i_inv_req && !clean_done)
                begin
                        state_nxt = INVALIDATE;
                end
        end

        SCAN:
        begin
                if (i_found)
                begin
                        line_idx_nxt = i_found_index;
                        word_nxt     = '0;
                        state_nxt    = READ_WAIT;
                end
                else if (group == GRP_W'(GROUPS - 1))
                begin
                        clean_done_nxt = 1'b1;
                        state_nxt      = IDLE;
                end
                else
                begin
                        group_nxt = group + 1'b1;
                end
        end

        // Line and tag of the chosen index arrive from the arrays.
        READ_WAIT:
        begin
                state_nxt = WRITE;
        end

        WRITE:
        begin
                word_nxt = word + CNT_W'(wb.stb && i_wb_ack);

                if (word_nxt == CNT_W'(WORDS))
                begin
                        // Burst finished, line is clean now.
                        o_clean    = 1'b1;
                        wb_nxt.cyc = 1'b0;
                        wb_nxt.stb = 1'b0;
                        wb_nxt.cti = CTI_EOB;
                        state_nxt  = SCAN;
                end
                else
                begin
                        wb_nxt.cyc = 1'b1;
                        wb_nxt.stb = 1'b1;
                        wb_nxt.wen = 1'b1;
                        wb_nxt.sel = 4'b1111;
                        wb_nxt.adr = i_tag.pa + {word_nxt, 2'b00};
                        wb_nxt.dat = i_line[word_nxt * 32 +: 32];
                        wb_nxt.cti = (word_nxt == CNT_W'(WORDS - 1)) ? CTI_EOB : CTI_BURST;
                end
        end

        INVALIDATE:
        begin
                o_clear    = 1'b1;
                o_inv_done = 1'b1;
                state_nxt  = IDLE;
        end

        default:
        begin
                state_nxt = IDLE;
        end
        endcase
end

endmodule

// ==== logic/dirty_scan.sv ====
// Dirty line search.
// Picks the lowest dirty line inside one group of the dirty vector and
// returns its full line index.

`timescale 1ns/100ps

module dirty_scan import cache_pkg::*; #(
        parameter int  CACHE_SIZE = 1024,
        parameter int  CACHE_LINE = 16,
        localparam int LINES      = CACHE_SIZE / CACHE_LINE,
        localparam int IDX_W      = $clog2(LINES),
        localparam int GROUPS     = LINES / GROUP_LINES,
        localparam int GRP_W      = (GROUPS > 1) ? $clog2(GROUPS) : 1
)(
        input  logic [LINES-1:0] i_dirty_vec,
        input  logic [GRP_W-1:0] i_group,
        output logic             o_found,
        output logic [IDX_W-1:0] o_index
);

localparam int SEL_W = $clog2(GROUP_LINES);

logic [GROUP_LINES-1:0] bits;
logic [SEL_W-1:0]       low;

// Dirty bits of the selected group.
assign bits = i_dirty_vec[i_group * GROUP_LINES +: GROUP_LINES];

// Priority encoder, walking down so the lowest set bit is kept.
always_comb
begin
        low     = '0;
        o_found = 1'b0;
        for (int i = GROUP_LINES - 1; i >= 0; i--)
        begin
                if (bits[i])
                begin
                        low     = SEL_W'(i);
                        o_found = 1'b1;
                end
        end
end

assign o_index = IDX_W'(i_group * GROUP_LINES) + IDX_W'(low);

endmodule

// ==== logic/line_ram.sv ====
// Line memory.
// One registered read port and one write port, write-first when both
// ports hit the same entry.

`timescale 1ns/100ps

module line_ram #(
        parameter int WIDTH = 32,
        parameter int DEPTH = 64
)(
        input  logic                     i_clk,
        input  logic                     i_wr_en,
        input  logic [$clog2(DEPTH)-1:0] i_wr_addr,
        input  logic [$clog2(DEPTH)-1:0] i_rd_addr,
        input  logic [WIDTH-1:0]         i_wr_data,
        output logic [WIDTH-1:0]         o_rd_data
);

logic [WIDTH-1:0] mem [DEPTH];

always_ff @(posedge i_clk)
begin
        if (i_wr_en)
        begin
                mem[i_wr_addr] <= i_wr_data;
        end
end

// New data wins on a same-edge address match.
always_ff @(posedge i_clk)
begin
        if (i_wr_en && (i_wr_addr == i_rd_addr))
        begin
                o_rd_data <= i_wr_data;
        end
        else
        begin
                o_rd_data <= mem[i_rd_addr];
        end
end

endmodule

// ==== logic/line_state.sv ====
// Valid and dirty state of every cache line.
// Lookup result is registered and follows a same-edge tag write, a clean
// of the read line and a global clear.

`timescale 1ns/100ps

module line_state #(
        parameter int  CACHE_SIZE = 1024,
        parameter int  CACHE_LINE = 16,
        localparam int LINES      = CACHE_SIZE / CACHE_LINE,
        localparam int IDX_W      = $clog2(LINES)
)(
        input  logic             i_clk,
        input  logic             i_reset,
        input  logic [IDX_W-1:0] i_rd_addr,
        input  logic [IDX_W-1:0] i_wr_addr,
        input  logic             i_wr_en,
        input  logic             i_wr_dirty,
        input  logic             i_clean,
        input  logic             i_clear,
        output logic             o_valid,
        output logic             o_dirty,
        output logic [LINES-1:0] o_dirty_vec
);

logic [LINES-1:0] valid;
logic [LINES-1:0] dirty;
logic             wr_hit;

assign wr_hit      = i_wr_en && (i_wr_addr == i_rd_addr);
assign o_dirty_vec = dirty;

// ----------------------------------------------------------------------

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                valid <= '0;
                dirty <= '0;
        end
        else
        begin
                if (i_clear)
                begin
                        valid <= '0;
                end
                else if (i_wr_en)
                begin
                        valid[i_wr_addr] <= 1'b1;
                end

                // Writes only happen in idle, cleans only outside it.
                if (i_wr_en)
                begin
                        dirty[i_wr_addr] <= i_wr_dirty;
                end
                else if (i_clean)
                begin
                        dirty[i_rd_addr] <= 1'b0;
                end
        end
end

// Lookup result.
always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                o_valid <= 1'b0;
                o_dirty <= 1'b0;
        end
        else
        begin
                o_valid <= !i_clear && (wr_hit || valid[i_rd_addr]);
                o_dirty <= wr_hit ? i_wr_dirty : (dirty[i_rd_addr] && !i_clean);
        end
end

endmodule

// ==== sources.f ====
logic/cache_pkg.sv
logic/line_ram.sv
logic/line_state.sv
logic/dirty_scan.sv
logic/clean_engine.sv
logic/cache_tag_ram.sv
tb/cache_tag_ram_props.sv
tb/cache_tag_ram_tb.sv

// ==== tb/cache_tag_ram_props.sv ====
// Bus and completion checks for the cache tag and data store.
// Bound into the store so that every run carries them.

`timescale 1ns/100ps

module cache_tag_ram_props
        import cache_pkg::*;
(
        input logic    i_clk,
        input logic    i_reset,
        input logic    i_clean_req,
        input logic    i_wb_ack,
        input logic    i_clean_done,
        input logic    i_inv_done,
        input wb_req_t i_wb
);

// A request waiting for acknowledge holds address, data and cycle type.
a_hold_request: assert property (@(posedge i_clk) disable iff (i_reset)
        i_wb.stb && !i_wb_ack |=> i_wb.stb && $stable(i_wb.adr) && $stable(i_wb.dat)
                && $stable(i_wb.cti))
        else $error("bus request changed before its acknowledge");

a_clean_pulse: assert property (@(posedge i_clk) disable iff (i_reset)
        i_clean_done |=> !i_clean_done)
        else $error("clean done held for more than one cycle");

a_inv_pulse: assert property (@(posedge i_clk) disable iff (i_reset)
        i_inv_done |=> !i_inv_done)
        else $error("invalidate done held for more than one cycle");

// Bus cycles only run while a clean is requested.
a_cyc_in_clean: assert property (@(posedge i_clk) disable iff (i_reset)
        i_wb.cyc |-> i_clean_req)
        else $error("bus cycle active outside a clean");

endmodule

bind cache_tag_ram cache_tag_ram_props u_props (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_clean_req  (i_clean_req),
        .i_wb_ack     (i_wb_ack),
        .i_clean_done (o_clean_done),
        .i_inv_done   (o_inv_done),
        .i_wb         (o_wb)
);

// ==== tb/cache_tag_ram_tb.sv ====
// Testbench for the cache tag and data store.
// Applies a table of writes, reads, cleans and invalidates, models the
// expected store contents and checks every write-back burst on the bus.

`timescale 1ns/100ps

module cache_tag_ram_tb
        import cache_pkg::*;
();

localparam int CACHE_SIZE = 1024;
localparam int CACHE_LINE = 16;
localparam int LINES      = CACHE_SIZE / CACHE_LINE;
localparam int WORDS      = CACHE_LINE / 4;
localparam int LINE_W     = CACHE_LINE * 8;
localparam int CLK_PERIOD = 20;
localparam int ROW_CYCLES = 200;

typedef enum logic [2:0] {
        OP_WRITE,
        OP_READ,
        OP_CLEAN,
        OP_INV,
        OP_SWEEP
} op_e;

typedef struct packed {
        op_e               op;
        logic [31:0]       addr;
        cache_tag_t        tag;
        logic              dirty;
        logic [LINE_W-1:0] line;
        logic              exp_valid;
        logic              exp_dirty;
} row_t;

logic              i_clk = 1'b0;
logic              i_reset;
logic [31:0]       i_address_nxt;
logic [31:0]       i_address;
logic              i_line_wr_en;
logic [LINE_W-1:0] i_line;
logic              i_tag_wr_en;
cache_tag_t        i_tag;
logic              i_tag_dirty;
logic              i_clean_req;
logic              i_inv_req;
logic              i_wb_ack;
logic [LINE_W-1:0] o_line;
cache_tag_t        o_tag;
logic              o_tag_valid;
logic              o_tag_dirty;
logic              o_clean_done;
logic              o_inv_done;
wb_req_t           o_wb;

// Expected store contents.
cache_tag_t        model_tag   [LINES];
logic [LINE_W-1:0] model_line  [LINES];
logic              model_valid [LINES];
logic              model_dirty [LINES];

// Bus transfers seen during the current clean, and the memory they reach.
logic [31:0]       xfer_adr [$];
logic [31:0]       xfer_dat [$];
logic [2:0]        xfer_cti [$];
logic [3:0]        xfer_sel [$];
logic              xfer_wen [$];
logic [31:0]       bus_mem  [logic [31:0]];

row_t              rows [$];
string             test_name;
int                errors = 0;
int                tests = 0;
int                failed = 0;
int                ack_wait = 0;
logic              ack_next = 1'b0;

cache_tag_ram #(
        .CACHE_SIZE    (CACHE_SIZE),
        .CACHE_LINE    (CACHE_LINE)
) dut (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_address_nxt (i_address_nxt),
        .i_address     (i_address),
        .i_line_wr_en  (i_line_wr_en),
        .i_line        (i_line),
        .i_tag_wr_en   (i_tag_wr_en),
        .i_tag         (i_tag),
        .i_tag_dirty   (i_tag_dirty),
        .i_clean_req   (i_clean_req),
        .i_inv_req     (i_inv_req),
        .i_wb_ack      (i_wb_ack),
        .o_line        (o_line),
        .o_tag         (o_tag),
        .o_tag_valid   (o_tag_valid),
        .o_tag_dirty   (o_tag_dirty),
        .o_clean_done  (o_clean_done),
        .o_inv_done    (o_inv_done),
        .o_wb          (o_wb)
);

always #(CLK_PERIOD / 2) i_clk = ~i_clk;

// ----------------------------------------------------------------------
// Bus slave model.
// Transfers are recorded at the falling edge and acknowledged after a
// random wait of 0 to 3 cycles.

always @(negedge i_clk)
begin
        if (i_reset)
        begin
                ack_next = 1'b0;
        end
        else if (o_wb.stb && i_wb_ack)
        begin
                xfer_adr.push_back(o_wb.adr);
                xfer_dat.push_back(o_wb.dat);
                xfer_cti.push_back(o_wb.cti);
                xfer_sel.push_back(o_wb.sel);
                xfer_wen.push_back(o_wb.wen);
                bus_mem[o_wb.adr] = o_wb.dat;
                ack_next = 1'b0;
                ack_wait = $urandom_range(3, 0);
        end
        else if (o_wb.stb)
        begin
                if (ack_wait == 0)
                begin
                        ack_next = 1'b1;
                end
                else
                begin
                        ack_wait--;
                end
        end
        else
        begin
                ack_next = 1'b0;
        end
end

always @(posedge i_clk)
begin
        i_wb_ack <= ack_next;
end

// ----------------------------------------------------------------------

function automatic int index_of(input logic [31:0] addr);
        return int'((addr / CACHE_LINE) % LINES);
endfunction

// Four distinct words per line with the seed itself in word 0.
function automatic logic [LINE_W-1:0] make_line(input logic [31:0] seed);
        return {seed ^ 32'h5a5aa5a5, {seed[15:0], seed[31:16]}, ~seed, seed};
endfunction

task automatic add_row(input op_e op, input logic [31:0] addr, input logic [VTAG_W-1:0] vtag,
                       input logic [31:0] pa, input logic dirty, input logic [31:0] seed,
                       input logic exp_valid, input logic exp_dirty);
        row_t row;
        row.op        = op;
        row.addr      = addr;
        row.tag.vtag  = vtag;
        row.tag.pa    = pa;
        row.dirty     = dirty;
        row.line      = make_line(seed);
        row.exp_valid = exp_valid;
        row.exp_dirty = exp_dirty;
        rows.push_back(row);
endtask

task automatic build_table();
        add_row(OP_SWEEP, 32'h000, 20'h0, 32'h0, 1'b0, 32'h0, 1'b0, 1'b0);
        add_row(OP_READ,  32'h000, 20'h0, 32'h0, 1'b0, 32'h0, 1'b0, 1'b0);
        add_row(OP_READ,  32'h3f0, 20'h0, 32'h0, 1'b0, 32'h0, 1'b0, 1'b0);
        add_row(OP_WRITE, 32'h050, 20'h12345, 32'h40001050, 1'b1, 32'ha5a50005, 1'b1, 1'b1);
        add_row(OP_READ,  32'h050, 20'h0, 32'h0, 1'b0, 32'h0, 1'b1, 1'b1);
        add_row(OP_WRITE, 32'h010, 20'h0abcd, 32'h40002010, 1'b1, 32'h12340001, 1'b1, 1'b1);
        add_row(OP_WRITE, 32'h200, 20'h00777, 32'h40003200, 1'b1, 32'hdead0020, 1'b1, 1'b1);
        add_row(OP_WRITE, 32'h0a0, 20'h00042, 32'h400040a0, 1'b0, 32'hbeef000a, 1'b1, 1'b0);
        add_row(OP_READ,  32'h0a0, 20'h0, 32'h0, 1'b0, 32'h0, 1'b1, 1'b0);
        add_row(OP_WRITE, 32'h3f0, 20'hfffff, 32'h400053f0, 1'b1, 32'h0f0f003f, 1'b1, 1'b1);
        add_row(OP_CLEAN, 32'h000, 20'h0, 32'h0, 1'b0, 32'h0, 1'b0, 1'b0);
        add_row(OP_READ,  32'h050, 20'h0, 32'h0, 1'b0, 32'h0, 1'b1, 1'b0);
        add_row(OP_READ,  32'h200, 20'h0, 32'h0, 1'b0, 32'h0, 1'b1, 1'b0);
        add_row(OP_SWEEP, 32'h000, 20'h0, 32'h0, 1'b0, 32'h0, 1'b0, 1'b0);
        // Nothing dirty is left, so this clean stays off the bus.
        add_row(OP_CLEAN, 32'h000, 20'h0, 32'h0, 1'b0, 32'h0, 1'b0, 1'b0);
        add_row(OP_WRITE, 32'h050, 20'h54321, 32'h40006050, 1'b1, 32'h77771005, 1'b1, 1'b1);
        add_row(OP_WRITE, 32'h120, 20'h01111, 32'h40007120, 1'b1, 32'h3c3c0012, 1'b1, 1'b1);
        add_row(OP_CLEAN, 32'h000, 20'h0, 32'h0, 1'b0, 32'h0, 1'b0, 1'b0);
        add_row(OP_INV,   32'h000, 20'h0, 32'h0, 1'b0, 32'h0, 1'b0, 1'b0);
        add_row(OP_READ,  32'h050, 20'h0, 32'h0, 1'b0, 32'h0, 1'b0, 1'b0);
        add_row(OP_READ,  32'h0a0, 20'h0, 32'h0, 1'b0, 32'h0, 1'b0, 1'b0);
        add_row(OP_SWEEP, 32'h000, 20'h0, 32'h0, 1'b0, 32'h0, 1'b0, 1'b0);
        add_row(OP_WRITE, 32'h0a0, 20'h00043, 32'h400080a0, 1'b1, 32'h5555000a, 1'b1, 1'b1);
        add_row(OP_READ,  32'h0a0, 20'h0, 32'h0, 1'b0, 32'h0, 1'b1, 1'b1);
endtask

// ----------------------------------------------------------------------
// Checks.

task automatic check_value(input string what, input logic [LINE_W-1:0] expected,
                           input logic [LINE_W-1:0] actual);
        assert (actual === expected)
        else
        begin
                $display("[ERROR] %s %s: expected %0h, actual %0h",
                         test_name, what, expected, actual);
                errors++;
        end
endtask

task automatic check_lookup(input logic exp_valid, input logic exp_dirty, input int idx);
        check_value($sformatf("valid[%0d]", idx), LINE_W'(exp_valid), LINE_W'(o_tag_valid));
        check_value($sformatf("dirty[%0d]", idx), LINE_W'(exp_dirty), LINE_W'(o_tag_dirty));
        if (exp_valid)
        begin
                check_value($sformatf("tag[%0d]", idx), LINE_W'(model_tag[idx]), LINE_W'(o_tag));
                check_value($sformatf("line[%0d]", idx), model_line[idx], o_line);
        end
endtask

// Expected bursts follow the dirty lines in ascending index order.
task automatic check_clean();
        logic [31:0] exp_adr [$];
        logic [31:0] exp_dat [$];
        logic [2:0]  exp_cti [$];
        int          n;
        for (int idx = 0; idx < LINES; idx++)
        begin
                if (model_dirty[idx])
                begin
                        for (int k = 0; k < WORDS; k++)
                        begin
                                exp_adr.push_back(model_tag[idx].pa + 32'(4 * k));
                                exp_dat.push_back(model_line[idx][32 * k +: 32]);
                                exp_cti.push_back((k == WORDS - 1) ? CTI_EOB : CTI_BURST);
                        end
                end
        end
        check_value("transfer count", LINE_W'(exp_adr.size()), LINE_W'(xfer_adr.size()));
        n = (exp_adr.size() < xfer_adr.size()) ? exp_adr.size() : xfer_adr.size();
        for (int i = 0; i < n; i++)
        begin
                check_value($sformatf("address %0d", i), LINE_W'(exp_adr[i]),
                            LINE_W'(xfer_adr[i]));
                check_value($sformatf("data %0d", i), LINE_W'(exp_dat[i]), LINE_W'(xfer_dat[i]));
                check_value($sformatf("cti %0d", i), LINE_W'(exp_cti[i]), LINE_W'(xfer_cti[i]));
                check_value($sformatf("sel %0d", i), LINE_W'(4'hf), LINE_W'(xfer_sel[i]));
                check_value($sformatf("wen %0d", i), LINE_W'(1'b1), LINE_W'(xfer_wen[i]));
        end
        for (int i = 0; i < exp_adr.size(); i++)
        begin
                assert (bus_mem.exists(exp_adr[i]))
                else
                begin
                        $display("[ERROR] %s: no bus write reached address %h",
                                 test_name, exp_adr[i]);
                        errors++;
                end
                if (bus_mem.exists(exp_adr[i]))
                begin
                        check_value($sformatf("memory %h", exp_adr[i]), LINE_W'(exp_dat[i]),
                                    LINE_W'(bus_mem[exp_adr[i]]));
                end
        end
endtask

// ----------------------------------------------------------------------
// Operations.

task automatic lookup(input logic [31:0] addr);
        @(posedge i_clk);
        i_address_nxt <= addr;
        @(posedge i_clk);
        @(negedge i_clk);
endtask

// The lookup runs on the write index too, so the result is write-first.
task automatic do_write(input row_t row);
        int idx;
        idx = index_of(row.addr);
        @(posedge i_clk);
        i_address     <= row.addr;
        i_address_nxt <= row.addr;
        i_line_wr_en  <= 1'b1;
        i_line        <= row.line;
        i_tag_wr_en   <= 1'b1;
        i_tag         <= row.tag;
        i_tag_dirty   <= row.dirty;
        @(posedge i_clk);
        i_line_wr_en  <= 1'b0;
        i_tag_wr_en   <= 1'b0;
        @(negedge i_clk);
        model_tag[idx]   = row.tag;
        model_line[idx]  = row.line;
        model_valid[idx] = 1'b1;
        model_dirty[idx] = row.dirty;
        check_lookup(row.exp_valid, row.exp_dirty, idx);
endtask

task automatic do_clean();
        xfer_adr.delete();
        xfer_dat.delete();
        xfer_cti.delete();
        xfer_sel.delete();
        xfer_wen.delete();
        @(posedge i_clk);
        i_clean_req <= 1'b1;
        @(negedge i_clk);
        while (!o_clean_done)
        begin
                @(negedge i_clk);
        end
        @(posedge i_clk);
        i_clean_req <= 1'b0;
        check_clean();
        for (int idx = 0; idx < LINES; idx++)
        begin
                model_dirty[idx] = 1'b0;
        end
endtask

// Done is due in the cycle right after the request is taken.
task automatic do_invalidate();
        int waited;
        waited = 1;
        @(posedge i_clk);
        i_inv_req <= 1'b1;
        @(negedge i_clk);
        while (!o_inv_done)
        begin
                @(negedge i_clk);
                waited++;
        end
        @(posedge i_clk);
        i_inv_req <= 1'b0;
        check_value("inv done latency", LINE_W'(2), LINE_W'(waited));
        for (int idx = 0; idx < LINES; idx++)
        begin
                model_valid[idx] = 1'b0;
        end
endtask

task automatic run_row(input int num, input row_t row);
        int errors_before;
        errors_before = errors;
        test_name = $sformatf("%0d_%s", num, row.op.name());
        case (row.op)
        OP_WRITE:
                do_write(row);
        OP_READ:
        begin
                lookup(row.addr);
                check_lookup(row.exp_valid, row.exp_dirty, index_of(row.addr));
        end
        OP_CLEAN:
                do_clean();
        OP_INV:
                do_invalidate();
        default:
        begin
                for (int idx = 0; idx < LINES; idx++)
                begin
                        lookup(32'(idx * CACHE_LINE));
                        check_lookup(model_valid[idx], model_dirty[idx], idx);
                end
        end
        endcase
        tests++;
        if (errors == errors_before)
        begin
                $display("test %s: ok", test_name);
        end
        else
        begin
                failed++;
                $display("test %s: fail, %0d errors", test_name, errors - errors_before);
        end
endtask

// ----------------------------------------------------------------------

initial
begin
        void'($urandom(32'hf675ace2));
        build_table();
        i_reset       = 1'b1;
        i_address_nxt = '0;
        i_address     = '0;
        i_line_wr_en  = 1'b0;
        i_line        = '0;
        i_tag_wr_en   = 1'b0;
        i_tag         = '0;
        i_tag_dirty   = 1'b0;
        i_clean_req   = 1'b0;
        i_inv_req     = 1'b0;
        i_wb_ack      = 1'b0;
        for (int idx = 0; idx < LINES; idx++)
        begin
                model_valid[idx] = 1'b0;
                model_dirty[idx] = 1'b0;
        end
        repeat (5) @(posedge i_clk);
        i_reset <= 1'b0;
        @(negedge i_clk);
        for (int i = 0; i < rows.size(); i++)
        begin
                run_row(i, rows[i]);
        end
        $display("Tests run: %0d, failed: %0d, errors: %0d", tests, failed, errors);
        if (errors == 0)
        begin
                $display("Result: PASSED");
        end
        else
        begin
                $display("Result: FAILED");
        end
        $finish;
end

// Watchdog sized from the number of table rows.
initial
begin
        @(negedge i_reset);
        #(CLK_PERIOD * ROW_CYCLES * rows.size());
        $display("Watchdog expired: the tests did not finish in time.");
        $display("Result: FAILED");
        $finish;
end

endmodule
